/* hw/cart_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cart_mem_top (
  input  logic                              CLK2,
  input  logic                              rst_n,
  input  cart_pkg::snes_pins_t              snes,
  input  cart_pkg::mcu_req_t                mcu_req,
  input  logic [cart_pkg::SNES_ADDR_W-1:0]  rom_mask,
  input  logic [2*cart_pkg::BYTE_W-1:0]     rom_data_in,
  output cart_pkg::mcu_rsp_t                mcu_rsp,
  output logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr,
  output logic [2*cart_pkg::BYTE_W-1:0]     rom_data_out,
  output logic                              rom_data_oe,
  output logic                              rom_we_n,
  output logic                              rom_bhe_n,
  output logic                              rom_ble_n,
  output logic [cart_pkg::BYTE_W-1:0]       snes_data_out,
  output logic                              snes_data_oe,
  output logic                              snes_reset_strobe
);

  cart_pkg::snes_evt_t              evt;
  logic                             snes_dead;
  logic                             rom_hit;
  logic [cart_pkg::BYTE_W-1:0]      rom_rbyte;
  logic [cart_pkg::SNES_ADDR_W-1:0] mcu_acc_addr;
  logic [cart_pkg::BYTE_W-1:0]      mcu_wdata;
  logic                             mcu_rd_busy;
  logic                             mcu_wr_busy;

  snes_bus_sync u_sync (
    .CLK2 (CLK2),
    .snes (snes),
    .evt  (evt)
  );

  snes_liveness u_live (
    .CLK2              (CLK2),
    .rst_n             (rst_n),
    .evt               (evt),
    .snes_dead         (snes_dead),
    .snes_reset_strobe (snes_reset_strobe)
  );

  rom_arbiter u_arb (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .evt          (evt),
    .snes_dead    (snes_dead),
    .rom_hit      (rom_hit),
    .rom_rbyte    (rom_rbyte),
    .mcu_req      (mcu_req),
    .mcu_rsp      (mcu_rsp),
    .mcu_acc_addr (mcu_acc_addr),
    .mcu_wdata    (mcu_wdata),
    .mcu_rd_busy  (mcu_rd_busy),
    .mcu_wr_busy  (mcu_wr_busy)
  );

  rom_bus_mux u_mux (
    .evt           (evt),
    .rom_mask      (rom_mask),
    .mcu_acc_addr  (mcu_acc_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_rd_busy   (mcu_rd_busy),
    .mcu_wr_busy   (mcu_wr_busy),
    .rom_data_in   (rom_data_in),
    .rom_hit       (rom_hit),
    .rom_rbyte     (rom_rbyte),
    .rom_addr      (rom_addr),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

  // ROM write only with data driven, and only inside an open MCU handshake
  a_rom_write_guard: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom_we_n |-> (rom_data_oe && !mcu_rsp.rdy));

endmodule

`default_nettype wire

/* hw/cart_pkg.sv */
`default_nettype none

package cart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths

  localparam int SNES_ADDR_W = 24;  // Console address
  localparam int ROM_ADDR_W  = 23;  // ROM word address
  localparam int BYTE_W      = 8;

  //////////////////////////////////////////////////////////////////////
  // Timing constants

  localparam int ROM_DLY_W = 4;
  localparam logic [ROM_DLY_W-1:0] ROM_CYCLE_LEN = 4'd7;  // ADDR state lasts LEN + 1

  // Roughly 1 ms of stalled console clock
  localparam int DEAD_CNT_W = 18;
  localparam logic [DEAD_CNT_W-1:0] SNES_DEAD_TIMEOUT = 18'd86000;

  localparam int SYNC_DEPTH = 8;  // Strobe shift register length
  localparam int ADDR_DLY   = 6;  // Address delay line stages
  localparam int DATA_DLY   = 4;  // Data delay line stages

  //////////////////////////////////////////////////////////////////////
  // Console bus

  typedef struct packed {
    logic [SNES_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      data;
    logic                   rd_n;
    logic                   wr_n;
    logic                   cpu_clk;
  } snes_pins_t;

  // Filtered levels plus one-cycle edge events
  typedef struct packed {
    logic [SNES_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      data;
    logic                   rd_n;
    logic                   wr_n;
    logic                   cpu_clk;
    logic                   rd_start;     // Read strobe fell
    logic                   rd_end;       // Read strobe rose
    logic                   cycle_start;  // cpu_clk rose
    logic                   cycle_end;    // cpu_clk fell
  } snes_evt_t;

  //////////////////////////////////////////////////////////////////////
  // MCU side

  typedef struct packed {
    logic                   rd_rq;
    logic                   wr_rq;
    logic [SNES_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      wdata;
  } mcu_req_t;

  typedef struct packed {
    logic              rdy;
    logic [BYTE_W-1:0] rdata;
  } mcu_rsp_t;

  // One-hot arbiter FSM encoding
  typedef enum logic [4:0] {
    IDLE    = 5'b00001,
    RD_ADDR = 5'b00010,
    RD_END  = 5'b00100,
    WR_ADDR = 5'b01000,
    WR_END  = 5'b10000
  } arb_state_e;

endpackage

`default_nettype wire

/* hw/rom_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module rom_arbiter (
  input  logic                              CLK2,
  input  logic                              rst_n,
  input  cart_pkg::snes_evt_t               evt,
  input  logic                              snes_dead,
  input  logic                              rom_hit,
  input  logic [cart_pkg::BYTE_W-1:0]       rom_rbyte,
  input  cart_pkg::mcu_req_t                mcu_req,
  output cart_pkg::mcu_rsp_t                mcu_rsp,
  output logic [cart_pkg::SNES_ADDR_W-1:0]  mcu_acc_addr,
  output logic [cart_pkg::BYTE_W-1:0]       mcu_wdata,
  output logic                              mcu_rd_busy,
  output logic                              mcu_wr_busy
);

  cart_pkg::arb_state_e state;

  logic [cart_pkg::ROM_DLY_W-1:0]   dly_cnt;
  logic [cart_pkg::SNES_ADDR_W-1:0] addr_q;
  logic [cart_pkg::BYTE_W-1:0]      wdata_q;
  logic [cart_pkg::BYTE_W-1:0]      rdata_q;
  logic rd_pend, wr_pend;
  logic rdy_q;
  logic free_strobe;
  logic free_slot;
  logic revive;
  logic acc_done;

  //////////////////////////////////////////////////////////////////////
  // Request capture and handshake

  assign acc_done = (state == cart_pkg::RD_END) || (state == cart_pkg::WR_END);

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;
    end else if (mcu_req.rd_rq) begin
      rd_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (mcu_req.wr_rq) begin
      wr_pend <= 1'b1;
      rdy_q   <= 1'b0;
    end else if (acc_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy_q   <= 1'b1;  // Rises one cycle after END
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_req.rd_rq | mcu_req.wr_rq) addr_q <= mcu_req.addr;
    if (mcu_req.wr_rq) wdata_q <= mcu_req.wdata;
    if (state == cart_pkg::RD_ADDR) rdata_q <= rom_rbyte;  // Last sample wins
  end

  //////////////////////////////////////////////////////////////////////
  // Free slots

  // Console cycle that did not touch ROM leaves the bus free
  always_ff @(posedge CLK2) begin
    if (!rst_n) free_strobe <= 1'b0;
    else        free_strobe <= evt.cycle_start & ~rom_hit;
  end

  assign free_slot = evt.cycle_end | free_strobe;
  assign revive    = snes_dead & evt.cpu_clk;

  //////////////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state   <= cart_pkg::IDLE;
      dly_cnt <= '0;
    end else if (revive) begin
      state <= cart_pkg::IDLE;  // Abort, request stays pending and restarts
    end else begin
      case (state)
        cart_pkg::IDLE: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state   <= cart_pkg::RD_ADDR;
              dly_cnt <= cart_pkg::ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state   <= cart_pkg::WR_ADDR;
              dly_cnt <= cart_pkg::ROM_CYCLE_LEN;
            end
          end
        end
        cart_pkg::RD_ADDR, cart_pkg::WR_ADDR: begin
          dly_cnt <= dly_cnt - 1'b1;
          if (dly_cnt == '0) begin
            state <= (state == cart_pkg::RD_ADDR) ? cart_pkg::RD_END : cart_pkg::WR_END;
          end
        end
        default: state <= cart_pkg::IDLE;  // Both END states
      endcase
    end
  end

  assign mcu_rsp.rdy   = rdy_q;
  assign mcu_rsp.rdata = rdata_q;
  assign mcu_acc_addr  = addr_q;
  assign mcu_wdata     = wdata_q;
  assign mcu_rd_busy   = (state == cart_pkg::RD_ADDR);
  assign mcu_wr_busy   = (state == cart_pkg::WR_ADDR);

  a_no_rq_while_busy: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_req.rd_rq | mcu_req.wr_rq) |-> rdy_q);
  a_single_rq: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(mcu_req.rd_rq && mcu_req.wr_rq));
  a_state_onehot: assert property (@(posedge CLK2) disable iff (!rst_n)
    $onehot(state));

endmodule

`default_nettype wire

/* hw/rom_bus_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module rom_bus_mux (
  input  cart_pkg::snes_evt_t               evt,
  input  logic [cart_pkg::SNES_ADDR_W-1:0]  rom_mask,
  input  logic [cart_pkg::SNES_ADDR_W-1:0]  mcu_acc_addr,
  input  logic [cart_pkg::BYTE_W-1:0]       mcu_wdata,
  input  logic                              mcu_rd_busy,
  input  logic                              mcu_wr_busy,
  input  logic [2*cart_pkg::BYTE_W-1:0]     rom_data_in,
  output logic                              rom_hit,
  output logic [cart_pkg::BYTE_W-1:0]       rom_rbyte,
  output logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr,
  output logic [2*cart_pkg::BYTE_W-1:0]     rom_data_out,
  output logic                              rom_data_oe,
  output logic                              rom_we_n,
  output logic                              rom_bhe_n,
  output logic                              rom_ble_n,
  output logic [cart_pkg::BYTE_W-1:0]       snes_data_out,
  output logic                              snes_data_oe
);

  logic [cart_pkg::SNES_ADDR_W-1:0] mapped_addr;
  logic [cart_pkg::SNES_ADDR_W-1:0] sel_addr;
  logic                             mcu_busy;
  logic                             lane_lo;

  //////////////////////////////////////////////////////////////////////
  // LoROM map, 32 KB of ROM in the upper half of each bank

  assign rom_hit     = evt.addr[15];
  assign mapped_addr = {2'b00, evt.addr[22:16], evt.addr[14:0]} & rom_mask;

  //////////////////////////////////////////////////////////////////////
  // Address and lanes

  assign mcu_busy = mcu_rd_busy | mcu_wr_busy;
  assign sel_addr = mcu_busy ? mcu_acc_addr : mapped_addr;
  assign rom_addr = sel_addr[cart_pkg::SNES_ADDR_W-1:1];
  assign lane_lo  = sel_addr[0];  // Odd byte sits in the low lane

  assign rom_bhe_n = lane_lo;
  assign rom_ble_n = ~lane_lo;

  assign rom_rbyte = lane_lo ? rom_data_in[cart_pkg::BYTE_W-1:0]
                             : rom_data_in[2*cart_pkg::BYTE_W-1:cart_pkg::BYTE_W];

  // MCU write, lane enables pick the byte
  assign rom_data_out = {2{mcu_wdata}};
  assign rom_data_oe  = mcu_wr_busy;
  assign rom_we_n     = ~mcu_wr_busy;

  //////////////////////////////////////////////////////////////////////
  // Console read return

  assign snes_data_oe  = ~evt.rd_n & rom_hit;
  assign snes_data_out = rom_rbyte;

endmodule

`default_nettype wire

/* hw/snes_bus_sync.sv */
`timescale 1ns/100ps
`default_nettype none

module snes_bus_sync (
  input  logic                 CLK2,
  input  cart_pkg::snes_pins_t snes,
  output cart_pkg::snes_evt_t  evt
);

  logic [cart_pkg::SYNC_DEPTH-1:0]  rd_sr;
  logic [cart_pkg::SYNC_DEPTH-1:0]  wr_sr;
  logic [cart_pkg::SYNC_DEPTH-1:0]  clk_sr;
  logic [cart_pkg::SNES_ADDR_W-1:0] addr_dl [cart_pkg::ADDR_DLY];
  logic [cart_pkg::BYTE_W-1:0]      data_dl [cart_pkg::DATA_DLY];
  logic rd_start_q, rd_end_q, cyc_start_q, cyc_end_q;

  // New level in two samples, old level steady in all older ones
  function automatic logic rise_seen(input logic [cart_pkg::SYNC_DEPTH-1:0] sr);
    rise_seen = sr[1] & sr[2] & ~(|sr[cart_pkg::SYNC_DEPTH-1:3]);
  endfunction

  function automatic logic fall_seen(input logic [cart_pkg::SYNC_DEPTH-1:0] sr);
    fall_seen = ~sr[1] & ~sr[2] & (&sr[cart_pkg::SYNC_DEPTH-1:3]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Sampling

  always_ff @(posedge CLK2) begin
    rd_sr  <= {rd_sr[cart_pkg::SYNC_DEPTH-2:0], snes.rd_n};
    wr_sr  <= {wr_sr[cart_pkg::SYNC_DEPTH-2:0], snes.wr_n};
    clk_sr <= {clk_sr[cart_pkg::SYNC_DEPTH-2:0], snes.cpu_clk};
    addr_dl[0] <= snes.addr;
    data_dl[0] <= snes.data;
    for (int i = 1; i < cart_pkg::ADDR_DLY; i++) begin
      addr_dl[i] <= addr_dl[i-1];
    end
    for (int i = 1; i < cart_pkg::DATA_DLY; i++) begin
      data_dl[i] <= data_dl[i-1];
    end
  end

  // Events land 3 cycles after the first sample of the new level
  always_ff @(posedge CLK2) begin
    rd_start_q  <= fall_seen(rd_sr);
    rd_end_q    <= rise_seen(rd_sr);
    cyc_start_q <= rise_seen(clk_sr);
    cyc_end_q   <= fall_seen(clk_sr);
  end

  //////////////////////////////////////////////////////////////////////
  // Filtered view

  always_comb begin
    evt.addr        = addr_dl[cart_pkg::ADDR_DLY-1] & addr_dl[cart_pkg::ADDR_DLY-2];
    evt.data        = data_dl[cart_pkg::DATA_DLY-1] & data_dl[cart_pkg::DATA_DLY-2];
    evt.rd_n        = rd_sr[2] & rd_sr[1];  // Low wins
    evt.wr_n        = wr_sr[2] & wr_sr[1];
    evt.cpu_clk     = clk_sr[2] & clk_sr[1];
    evt.rd_start    = rd_start_q;
    evt.rd_end      = rd_end_q;
    evt.cycle_start = cyc_start_q;
    evt.cycle_end   = cyc_end_q;
  end

endmodule

`default_nettype wire

/* hw/snes_liveness.sv */
`timescale 1ns/100ps
`default_nettype none

module snes_liveness (
  input  logic                CLK2,
  input  logic                rst_n,
  input  cart_pkg::snes_evt_t evt,
  output logic                snes_dead,
  output logic                snes_reset_strobe
);

  logic [cart_pkg::DEAD_CNT_W-1:0] stall_cnt;

  // Stall counter saturates instead of wrapping
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      stall_cnt <= '0;
    end else if (evt.cpu_clk) begin
      stall_cnt <= '0;
    end else if (~&stall_cnt) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      snes_dead         <= 1'b1;  // Assume no console until its clock runs
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (evt.cpu_clk) begin
        snes_dead <= 1'b0;
        if (snes_dead) snes_reset_strobe <= 1'b1;  // Revival
      end else if (stall_cnt > cart_pkg::SNES_DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // Revival is a single pulse
  a_strobe_single: assert property (@(posedge CLK2) disable iff (!rst_n)
    snes_reset_strobe |=> !snes_reset_strobe);

endmodule

`default_nettype wire

/* list.f */
+incdir+tb
hw/cart_pkg.sv
hw/snes_bus_sync.sv
hw/snes_liveness.sv
hw/rom_arbiter.sv
hw/rom_bus_mux.sv
hw/cart_mem_top.sv
tb/tb_cart_mem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_cart_mem -o sim_cart_mem
./obj_dir/sim_cart_mem > sim.log 2>&1 || true
cat sim.log

grep -q "Verification passed" sim.log
echo "Simulation passed"

/* tb/tb_cart_mem_checks.svh */
`ifndef TB_CART_MEM_CHECKS_SVH
`define TB_CART_MEM_CHECKS_SVH

int chk_errors   = 0;
int other_errors = 0;

////////////////////////////////////////////////////////////////////////
// Window flags and expected values driven by the stimulus tasks

logic        before_req;  // Quiet window from reset to first request
logic        dead_chk;
logic        rd_chk;
logic        nohit_chk;
logic        hold_chk;    // No free slot, rdy must stay low
logic        strobe_chk;
logic [23:0] exp_addr;
logic [7:0]  exp_wdata;
logic [7:0]  exp_rdata;
logic [23:0] con_addr;
int          strobe_cnt;

a_quiet_after_reset: assert property (@(posedge CLK2) disable iff (!rst_n)
  before_req |-> (mcu_rsp.rdy && rom_we_n && !snes_data_oe))
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rdy/rom_we_n/snes_data_oe expected 110 got %b%b%b",
             $time, $sampled(mcu_rsp.rdy), $sampled(rom_we_n), $sampled(snes_data_oe));
  end

a_console_dead: assert property (@(posedge CLK2) disable iff (!rst_n)
  dead_chk |-> u_dut.snes_dead)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t snes_dead expected 1 got 0", $time);
  end

// Only the testbench's own writes reach the ROM bus
a_wr_addr: assert property (@(posedge CLK2) disable iff (!rst_n)
  !rom_we_n |-> rom_addr == exp_addr[23:1])
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rom_addr expected %h got %h",
             $time, exp_addr[23:1], $sampled(rom_addr));
  end

a_wr_lanes: assert property (@(posedge CLK2) disable iff (!rst_n)
  !rom_we_n |-> (rom_ble_n == !exp_addr[0] && rom_bhe_n == exp_addr[0]))
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t bhe_n/ble_n expected %b%b got %b%b", $time,
             exp_addr[0], !exp_addr[0], $sampled(rom_bhe_n), $sampled(rom_ble_n));
  end

a_wr_data: assert property (@(posedge CLK2) disable iff (!rst_n)
  !rom_we_n |-> rom_data_out == {2{exp_wdata}})
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rom_data_out expected %h got %h",
             $time, {2{exp_wdata}}, $sampled(rom_data_out));
  end

a_wr_oe: assert property (@(posedge CLK2) disable iff (!rst_n)
  !rom_we_n |-> rom_data_oe)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rom_data_oe expected 1 got 0", $time);
  end

a_rd_data: assert property (@(posedge CLK2) disable iff (!rst_n)
  (rd_chk && $rose(mcu_rsp.rdy)) |-> mcu_rsp.rdata == exp_rdata)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rdata expected %h got %h",
             $time, exp_rdata, $sampled(mcu_rsp.rdata));
  end

a_con_data: assert property (@(posedge CLK2) disable iff (!rst_n)
  snes_data_oe |-> snes_data_out == model_byte(lorom_map(con_addr)))
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t snes_data_out expected %h got %h", $time,
             model_byte(lorom_map(con_addr)), $sampled(snes_data_out));
  end

a_no_hit: assert property (@(posedge CLK2) disable iff (!rst_n)
  nohit_chk |-> !snes_data_oe)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t snes_data_oe expected 0 got 1", $time);
  end

a_hold_busy: assert property (@(posedge CLK2) disable iff (!rst_n)
  hold_chk |-> !mcu_rsp.rdy)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t rdy expected 0 got 1", $time);
  end

a_strobe_once: assert property (@(posedge CLK2) disable iff (!rst_n)
  strobe_chk |-> strobe_cnt == 1)
  else begin
    chk_errors++;
    $display("CHECK FAILED t=%0t snes_reset_strobe count expected 1 got %0d",
             $time, strobe_cnt);
  end

a_req_when_ready: assert property (@(posedge CLK2) disable iff (!rst_n)
  (mcu_req.rd_rq || mcu_req.wr_rq) |-> mcu_rsp.rdy)
  else begin
    other_errors++;
    $display("ERROR t=%0t MCU request issued while rdy was low", $time);
  end

`endif

/* tb/tb_cart_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cart_mem;

  localparam int CLK_PERIOD  = 20;
  localparam int TEST_CYCLES = 86800;  // Dominated by the dead console wait

  logic                 CLK2;
  logic                 rst_n;
  cart_pkg::snes_pins_t snes;
  cart_pkg::mcu_req_t   mcu_req;
  cart_pkg::mcu_rsp_t   mcu_rsp;
  logic [23:0]          rom_mask;
  logic [15:0]          rom_data_in;
  logic [22:0]          rom_addr;
  logic [15:0]          rom_data_out;
  logic                 rom_data_oe;
  logic                 rom_we_n;
  logic                 rom_bhe_n;
  logic                 rom_ble_n;
  logic [7:0]           snes_data_out;
  logic                 snes_data_oe;
  logic                 snes_reset_strobe;

  logic [15:0] rom_mem [65536];

  // Odd bytes of the ROM model sit in the low lane
  function automatic logic [7:0] model_byte(input logic [23:0] a);
    logic [15:0] w;
    w = rom_mem[a[16:1]];
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  // Each bank maps 32 KB of ROM
  function automatic logic [23:0] lorom_map(input logic [23:0] a);
    logic [23:0] bank;
    bank = 24'(a[22:16]);
    return (bank * 24'h8000 + 24'(a[14:0])) & rom_mask;
  endfunction

  `include "tb_cart_mem_checks.svh"

  cart_mem_top u_dut (
    .CLK2              (CLK2),
    .rst_n             (rst_n),
    .snes              (snes),
    .mcu_req           (mcu_req),
    .rom_mask          (rom_mask),
    .rom_data_in       (rom_data_in),
    .mcu_rsp           (mcu_rsp),
    .rom_addr          (rom_addr),
    .rom_data_out      (rom_data_out),
    .rom_data_oe       (rom_data_oe),
    .rom_we_n          (rom_we_n),
    .rom_bhe_n         (rom_bhe_n),
    .rom_ble_n         (rom_ble_n),
    .snes_data_out     (snes_data_out),
    .snes_data_oe      (snes_data_oe),
    .snes_reset_strobe (snes_reset_strobe)
  );

  initial begin
    CLK2 = 1'b0;
    forever #(CLK_PERIOD / 2) CLK2 = ~CLK2;
  end

  ////////////////////////////////////////////////////////////////////
  // ROM model

  assign rom_data_in = rom_mem[rom_addr[15:0]];

  always @(posedge CLK2) begin
    if (!rom_we_n) begin
      if (!rom_ble_n) rom_mem[rom_addr[15:0]][7:0] <= rom_data_out[7:0];
      if (!rom_bhe_n) rom_mem[rom_addr[15:0]][15:8] <= rom_data_out[15:8];
    end
  end

  always @(posedge CLK2) begin
    if (rst_n && snes_reset_strobe) strobe_cnt <= strobe_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus tasks

  // One-cycle request pulse that returns once rdy has dropped
  task automatic mcu_request(input logic is_rd, input logic [23:0] addr,
                             input logic [7:0] wdata);
    while (!mcu_rsp.rdy) @(posedge CLK2);
    mcu_req.addr  <= addr;
    mcu_req.wdata <= wdata;
    mcu_req.rd_rq <= is_rd;
    mcu_req.wr_rq <= !is_rd;
    before_req    <= 1'b0;
    @(posedge CLK2);
    mcu_req.rd_rq <= 1'b0;
    mcu_req.wr_rq <= 1'b0;
    @(posedge CLK2);
  endtask

  task automatic wait_rdy(input int limit);
    int n;
    n = 0;
    while (!mcu_rsp.rdy && n < limit) begin
      @(posedge CLK2);
      n++;
    end
    if (!mcu_rsp.rdy) begin
      other_errors++;
      $display("ERROR t=%0t MCU access got no rdy within %0d cycles", $time, limit);
    end
    rd_chk <= 1'b0;
  endtask

  task automatic mcu_read(input logic [23:0] addr, input logic [7:0] expected);
    exp_rdata <= expected;
    rd_chk    <= 1'b1;
    mcu_request(1'b1, addr, 8'h00);
    wait_rdy(100);
  endtask

  task automatic console_read(input logic [23:0] addr, input logic expect_hit);
    snes.addr <= addr;
    con_addr  <= addr;
    repeat (8) @(posedge CLK2);  // Let the address delay line settle
    nohit_chk <= !expect_hit;
    snes.rd_n <= 1'b0;
    repeat (6) @(posedge CLK2);
    snes.rd_n <= 1'b1;
    repeat (8) @(posedge CLK2);
    nohit_chk <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0] r;
    logic [23:0] a;
    logic [7:0]  d;
    void'($urandom(32'h4030_dd0f));
    for (int i = 0; i < 65536; i++) begin
      r = $urandom();
      rom_mem[i] = r[15:0];
    end
    rst_n      = 1'b0;
    snes       = '0;
    snes.rd_n  = 1'b1;
    snes.wr_n  = 1'b1;
    mcu_req    = '0;
    rom_mask   = 24'h01_FFFF;  // 128 KB ROM
    before_req = 1'b1;
    dead_chk   = 1'b0;
    rd_chk     = 1'b0;
    nohit_chk  = 1'b0;
    hold_chk   = 1'b0;
    strobe_chk = 1'b0;
    exp_addr   = '0;
    exp_wdata  = '0;
    exp_rdata  = '0;
    con_addr   = '0;
    strobe_cnt = 0;
    repeat (10) @(posedge CLK2);
    rst_n <= 1'b1;
    repeat (20) @(posedge CLK2);

    // Console clock stalled past the timeout
    repeat (int'(cart_pkg::SNES_DEAD_TIMEOUT) + 10) @(posedge CLK2);
    dead_chk <= 1'b1;
    r = $urandom();
    a = {7'd0, r[16:0]};
    d = r[31:24];
    exp_addr  <= a;
    exp_wdata <= d;
    mcu_request(1'b0, a, d);
    wait_rdy(100);
    mcu_read(a, d);

    // Random read from the dead console side
    r = $urandom();
    a = {7'd0, r[16:0]};
    mcu_read(a, model_byte(a));
    dead_chk <= 1'b0;

    // Four console reads in ROM space and two outside it
    for (int i = 0; i < 4; i++) begin
      r = $urandom();
      console_read({1'b0, r[22:16], 1'b1, r[14:0]}, 1'b1);
    end
    for (int i = 0; i < 2; i++) begin
      r = $urandom();
      console_read({1'b0, r[22:16], 1'b0, r[14:0]}, 1'b0);
    end

    // Console revives and keeps its clock high
    snes.cpu_clk <= 1'b1;
    repeat (20) @(posedge CLK2);
    strobe_chk <= 1'b1;
    @(posedge CLK2);
    strobe_chk <= 1'b0;
    r = $urandom();
    a = {7'd0, r[16:0]};
    exp_rdata <= model_byte(a);
    rd_chk    <= 1'b1;
    mcu_request(1'b1, a, 8'h00);
    hold_chk <= 1'b1;
    repeat (200) @(posedge CLK2);
    hold_chk     <= 1'b0;
    snes.cpu_clk <= 1'b0;  // cycle_end opens a slot
    wait_rdy(int'(cart_pkg::ROM_CYCLE_LEN) + 10);

    repeat (5) @(posedge CLK2);
    $display("Closing report: %0d check errors, %0d other errors", chk_errors, other_errors);
    if (chk_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog at 1.5 times the expected run length
  initial begin
    #(64'(TEST_CYCLES) * CLK_PERIOD * 3 / 2);
    $display("ERROR watchdog expired, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
